/* vlog.f */
logic/csr_index_pkg.sv
logic/csr_index_configure.sv
logic/csr_index_fifo.sv
logic/csr_index_generator.sv
logic/csr_index_engine.sv
bench/csr_index_tb.sv

/* Makefile */
TOP = csr_index_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* bench/csr_index_tb.sv */
/*
 * Testbench for the CSR index engine with clock, reset, config stimulus,
 * Wishbone slave model, scoreboard and assertions
 */

`timescale 1ns/1ps

module csr_index_tb;

    // Expected reads in the order the packets must come out
    typedef struct packed {
        logic [csr_index_pkg::DATA_W-1:0] index;
        logic [csr_index_pkg::DATA_W-1:0] addr;
        logic                             last;
    } exp_entry_t;

    logic                       ap_clk;
    logic                       areset_csr_engine;
    csr_index_pkg::descriptor_t descriptor;
    csr_index_pkg::cfg_word_t   cfg_word;
    logic                       cfg_ready;
    csr_index_pkg::wb_req_t     wb_req;
    csr_index_pkg::wb_rsp_t     wb_rsp = '0;
    csr_index_pkg::idx_pkt_t    pkt;
    logic                       done;

    // Reference model of the held record and the job
    logic [csr_index_pkg::DATA_W-1:0] m_base = '0;
    logic [csr_index_pkg::DATA_W-1:0] m_first = '0;
    logic [csr_index_pkg::DATA_W-1:0] m_last = '0;
    exp_entry_t                       exp_q[$];
    int                               committed_in_job = 0;
    int                               job_count_exp = 0;
    int                               ranges_open = 0;
    logic                             saw_full = 1'b0;

    // Slave model state
    integer seed = 32'h32df_16a5;
    int     ack_delay = 0;
    logic   slave_busy = 1'b0;

    csr_index_engine i_csr_index_engine (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .descriptor_i      (descriptor),
        .cfg_word_i        (cfg_word),
        .cfg_ready_o       (cfg_ready),
        .wb_req_o          (wb_req),
        .wb_rsp_i          (wb_rsp),
        .pkt_o             (pkt),
        .done_o            (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic finish_failed();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        finish_failed();
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        finish_failed();
    endtask

    // --------------------
    // Stimulus
    // --------------------
    // Mirror of the producer that queues expected reads on COMMIT
    task automatic record_cfg(input csr_index_pkg::cfg_op_e op,
                              input logic [csr_index_pkg::DATA_W-1:0] data);
        exp_entry_t                       entry;
        logic [csr_index_pkg::DATA_W-1:0] idx;
        case (op)
            csr_index_pkg::CFG_BASE:  m_base = data;
            csr_index_pkg::CFG_FIRST: m_first = data;
            csr_index_pkg::CFG_LAST:  m_last = data;
            default: begin
                committed_in_job++;
                if (m_first <= m_last) begin
                    ranges_open++;
                    idx = m_first;
                    do begin
                        entry.index = idx;
                        entry.addr  = m_base + idx * 32'(csr_index_pkg::ENTRY_BYTES);
                        entry.last  = (idx == m_last);
                        exp_q.push_back(entry);
                        idx = idx + 32'd1;
                    end while (!entry.last);
                end
            end
        endcase
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic send_cfg(input csr_index_pkg::cfg_op_e op,
                            input logic [csr_index_pkg::DATA_W-1:0] data);
        int guard;
        guard = 0;
        cfg_word.valid = 1'b1;
        cfg_word.op    = op;
        cfg_word.data  = data;
        while (!cfg_ready) begin
            @(negedge ap_clk);
            guard++;
            if (guard > 500) begin
                abort_run("timeout waiting for config ready");
            end
        end
        record_cfg(op, data);
        @(negedge ap_clk);
        cfg_word.valid = 1'b0;
    endtask

    task automatic load_descriptor(input logic [csr_index_pkg::COUNT_W-1:0] count);
        descriptor.valid     = 1'b1;
        descriptor.job_count = count;
        @(negedge ap_clk);
        descriptor.valid = 1'b0;
        job_count_exp    = count;
        committed_in_job = 0;
        assert (!done) else mismatch("done_o", done, 0);
    endtask

    task automatic wait_done();
        int guard;
        guard = 0;
        while (!done) begin
            @(negedge ap_clk);
            guard++;
            if (guard > 3000) begin
                abort_run("timeout waiting for done_o");
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge ap_clk);
        end
    endtask

    // --------------------
    // Checks and Wishbone slave
    // --------------------
    always @(negedge ap_clk) begin : check_and_respond
        exp_entry_t head;
        if (!areset_csr_engine) begin
            assert (wb_req.cyc == wb_req.stb)
                else mismatch("wb_req_o.cyc", wb_req.cyc, wb_req.stb);
            assert (!wb_req.we) else mismatch("wb_req_o.we", wb_req.we, 0);
            if (wb_req.stb) begin
                assert (exp_q.size() > 0) else abort_run("Wishbone read with no index expected");
                assert (wb_req.adr == exp_q[0].addr)
                    else mismatch("wb_req_o.adr", wb_req.adr, exp_q[0].addr);
            end
            if (pkt.valid) begin
                assert (exp_q.size() > 0) else abort_run("index packet with none expected");
                head = exp_q.pop_front();
                assert (pkt.index == head.index)
                    else mismatch("pkt_o.index", pkt.index, head.index);
                assert (pkt.data == ~head.addr)
                    else mismatch("pkt_o.data", pkt.data, ~head.addr);
                if (head.last) begin
                    ranges_open--;
                end
            end
            // Done only once every range of the job has come out
            assert (!done || (exp_q.size() == 0 && job_count_exp != 0
                              && committed_in_job >= job_count_exp))
                else mismatch("done_o", done, 0);
            // A full buffer means at least four ranges are still unfinished
            assert (cfg_ready || ranges_open >= csr_index_pkg::FIFO_DEPTH)
                else mismatch("cfg_ready_o", cfg_ready, 1);
            if (!cfg_ready) begin
                saw_full = 1'b1;
            end
        end
        // Ack after 0 to 5 cycles with the inverted address as read data
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!slave_busy) begin
                slave_busy = 1'b1;
                ack_delay  = $unsigned($random(seed)) % 6;
            end
            if (ack_delay == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = ~wb_req.adr;
                slave_busy = 1'b0;
            end else begin
                ack_delay--;
            end
        end
    end

    req_held: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
        else abort_run("stb dropped or adr moved before ack");

    req_drop: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        (wb_req.stb && wb_rsp.ack) |=> (!wb_req.stb && pkt.valid))
        else abort_run("no packet or no idle cycle after ack");

    pkt_pulse: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        pkt.valid |=> !pkt.valid)
        else abort_run("packet valid held longer than one cycle");

    initial begin
        repeat (50000) @(posedge ap_clk);
        abort_run("simulation watchdog expired");
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        areset_csr_engine = 1'b1;
        descriptor        = '0;
        cfg_word          = '0;
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        assert (!wb_req.cyc) else mismatch("wb_req_o.cyc", wb_req.cyc, 0);
        assert (!wb_req.stb) else mismatch("wb_req_o.stb", wb_req.stb, 0);
        assert (!pkt.valid) else mismatch("pkt_o.valid", pkt.valid, 0);
        assert (!done) else mismatch("done_o", done, 0);
        assert (cfg_ready) else mismatch("cfg_ready_o", cfg_ready, 1);

        // Single range
        load_descriptor(1);
        send_cfg(csr_index_pkg::CFG_BASE, 32'h0000_1000);
        send_cfg(csr_index_pkg::CFG_FIRST, 32'd3);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd7);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        wait_done();

        // Empty range still counts and done waits for the second one
        load_descriptor(2);
        send_cfg(csr_index_pkg::CFG_FIRST, 32'd9);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd4);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        idle_cycles(12);
        send_cfg(csr_index_pkg::CFG_FIRST, 32'd0);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd2);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        wait_done();

        // Second commit only rewrites LAST
        load_descriptor(2);
        send_cfg(csr_index_pkg::CFG_BASE, 32'h0000_8000);
        send_cfg(csr_index_pkg::CFG_FIRST, 32'd10);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd12);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd14);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        wait_done();

        // Six ranges back to back against a slow slave
        saw_full = 1'b0;
        load_descriptor(6);
        send_cfg(csr_index_pkg::CFG_BASE, 32'h0002_0000);
        send_cfg(csr_index_pkg::CFG_FIRST, 32'd0);
        send_cfg(csr_index_pkg::CFG_LAST, 32'd7);
        send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        for (int k = 1; k < 6; k++) begin
            send_cfg(csr_index_pkg::CFG_LAST, 32'(7 + k));
            send_cfg(csr_index_pkg::CFG_COMMIT, 32'd0);
        end
        wait_done();
        assert (saw_full) else abort_run("config ready never dropped with six ranges queued");

        idle_cycles(4);
        $display("Result: PASSED");
        $finish;
    end

endmodule : csr_index_tb

/* logic/csr_index_engine.sv */
/*
 * CSR index engine top, config collector feeding a range FIFO that
 * feeds the Wishbone read generator
 */

`timescale 1ns/1ps

module csr_index_engine (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  csr_index_pkg::descriptor_t descriptor_i,
    input  csr_index_pkg::cfg_word_t   cfg_word_i,
    output logic                       cfg_ready_o,
    output csr_index_pkg::wb_req_t     wb_req_o,
    input  csr_index_pkg::wb_rsp_t     wb_rsp_i,
    output csr_index_pkg::idx_pkt_t    pkt_o,
    output logic                       done_o
);

    // --------------------
    // Internal wires
    // --------------------
    logic                      buf_full;
    logic                      buf_empty;
    logic                      buf_push;
    logic                      buf_pop;
    csr_index_pkg::csr_range_t push_range;
    csr_index_pkg::csr_range_t head_range;

    // Configuration words into range records
    csr_index_configure i_csr_index_configure (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg_word_i        (cfg_word_i),
        .cfg_ready_o       (cfg_ready_o),
        .buf_full_i        (buf_full),
        .push_o            (buf_push),
        .range_o           (push_range)
    );

    // Queue between configuration and generation
    csr_index_fifo i_csr_index_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .push_i            (buf_push),
        .range_i           (push_range),
        .pop_i             (buf_pop),
        .range_o           (head_range),
        .empty_o           (buf_empty),
        .full_o            (buf_full)
    );

    // Wishbone reads and index packets
    csr_index_generator i_csr_index_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .descriptor_i      (descriptor_i),
        .range_i           (head_range),
        .buf_empty_i       (buf_empty),
        .pop_o             (buf_pop),
        .wb_req_o          (wb_req_o),
        .wb_rsp_i          (wb_rsp_i),
        .pkt_o             (pkt_o),
        .done_o            (done_o)
    );

endmodule : csr_index_engine

/* logic/csr_index_generator.sv */
/*
 * Request generator, walks each buffered range with one Wishbone read per
 * index, emits index packets and tracks job completion for done_o
 */

`timescale 1ns/1ps

module csr_index_generator (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  csr_index_pkg::descriptor_t descriptor_i,
    input  csr_index_pkg::csr_range_t  range_i,
    input  logic                       buf_empty_i,
    output logic                       pop_o,
    output csr_index_pkg::wb_req_t     wb_req_o,
    input  csr_index_pkg::wb_rsp_t     wb_rsp_i,
    output csr_index_pkg::idx_pkt_t    pkt_o,
    output logic                       done_o
);

    csr_index_pkg::gen_state_e state_q;
    csr_index_pkg::gen_state_e state_d;

    logic [csr_index_pkg::DATA_W-1:0]  base_q;
    logic [csr_index_pkg::DATA_W-1:0]  last_q;
    logic [csr_index_pkg::DATA_W-1:0]  index_q;
    logic [csr_index_pkg::COUNT_W-1:0] job_count_q;
    logic [csr_index_pkg::COUNT_W-1:0] completed_q;

    logic job_pending;
    logic range_empty;
    logic last_ack;

    assign job_pending = (completed_q < job_count_q);
    // Head record holds first > last, nothing to read
    assign range_empty = (range_i.first > range_i.last);
    assign last_ack    = (state_q == csr_index_pkg::GEN_REQ) & wb_rsp_i.ack
                         & (index_q == last_q);

    // --------------------
    // FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            csr_index_pkg::GEN_IDLE: begin
                if (!buf_empty_i && job_pending) begin
                    state_d = csr_index_pkg::GEN_LOAD;
                end
            end
            csr_index_pkg::GEN_LOAD: begin
                state_d = range_empty ? csr_index_pkg::GEN_IDLE : csr_index_pkg::GEN_REQ;
            end
            csr_index_pkg::GEN_REQ: begin
                if (wb_rsp_i.ack) begin
                    state_d = csr_index_pkg::GEN_NEXT;
                end
            end
            default: begin
                state_d = (index_q == last_q) ? csr_index_pkg::GEN_IDLE
                                              : csr_index_pkg::GEN_REQ;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q <= csr_index_pkg::GEN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Head record is taken in LOAD, one cycle after IDLE saw it
    assign pop_o = (state_q == csr_index_pkg::GEN_LOAD);

    // --------------------
    // Range walk
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (state_q == csr_index_pkg::GEN_LOAD) begin
            base_q  <= range_i.base;
            last_q  <= range_i.last;
            index_q <= range_i.first;
        end else if (state_q == csr_index_pkg::GEN_NEXT && index_q != last_q) begin
            index_q <= index_q + 1'b1;
        end
    end

    // cyc/stb follow the registered state, adr is stable through REQ
    assign wb_req_o.cyc = (state_q == csr_index_pkg::GEN_REQ);
    assign wb_req_o.stb = (state_q == csr_index_pkg::GEN_REQ);
    assign wb_req_o.we  = 1'b0;
    assign wb_req_o.adr = base_q + index_q * csr_index_pkg::DATA_W'(csr_index_pkg::ENTRY_BYTES);

    // --------------------
    // Index packets
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            pkt_o.valid <= 1'b0;
        end else begin
            pkt_o.valid <= (state_q == csr_index_pkg::GEN_REQ) & wb_rsp_i.ack;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wb_rsp_i.ack) begin
            pkt_o.index <= index_q;
            pkt_o.data  <= wb_rsp_i.dat;
        end
    end

    // --------------------
    // Job tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            job_count_q <= '0;
            completed_q <= '0;
            done_o      <= 1'b0;
        end else if (descriptor_i.valid) begin
            job_count_q <= descriptor_i.job_count;
            completed_q <= '0;
            done_o      <= 1'b0;
        end else begin
            if (last_ack || (state_q == csr_index_pkg::GEN_LOAD && range_empty)) begin
                completed_q <= completed_q + 1'b1;
            end
            // Sticky until the next descriptor
            if (completed_q == job_count_q && buf_empty_i && job_count_q != '0) begin
                done_o <= 1'b1;
            end
        end
    end

endmodule : csr_index_generator

/* logic/csr_index_fifo.sv */
/*
 * Synchronous FIFO of range records between configuration and generator
 */

`timescale 1ns/1ps

module csr_index_fifo (
    input  logic                      ap_clk,
    input  logic                      areset_csr_engine,
    input  logic                      push_i,
    input  csr_index_pkg::csr_range_t range_i,
    input  logic                      pop_i,
    output csr_index_pkg::csr_range_t range_o,
    output logic                      empty_o,
    output logic                      full_o
);

    csr_index_pkg::csr_range_t mem_q [csr_index_pkg::FIFO_DEPTH];

    logic [csr_index_pkg::FIFO_AW-1:0] wr_ptr_q;
    logic [csr_index_pkg::FIFO_AW-1:0] rd_ptr_q;
    logic [csr_index_pkg::FIFO_AW:0]   count_q;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= range_i;
        end
    end

    // --------------------
    // Pointers and occupancy
    // --------------------
    // Depth is a power of two, so the pointers wrap by themselves
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head is valid whenever the buffer is not empty
    assign range_o = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (csr_index_pkg::FIFO_AW + 1)'(csr_index_pkg::FIFO_DEPTH));

endmodule : csr_index_fifo

/* logic/csr_index_configure.sv */
/*
 * Configuration collector, decodes config words into a held range record
 * and pushes that record into the buffer on COMMIT
 */

`timescale 1ns/1ps

module csr_index_configure (
    input  logic                      ap_clk,
    input  logic                      areset_csr_engine,
    input  csr_index_pkg::cfg_word_t  cfg_word_i,
    output logic                      cfg_ready_o,
    input  logic                      buf_full_i,
    output logic                      push_o,
    output csr_index_pkg::csr_range_t range_o
);

    // --------------------
    // Handshake
    // --------------------
    logic                      cfg_accept;
    csr_index_pkg::csr_range_t range_q;

    // Words are only taken while the buffer has room
    assign cfg_ready_o = ~buf_full_i;
    assign cfg_accept  = cfg_word_i.valid & cfg_ready_o;

    // --------------------
    // Held range record
    // --------------------
    // Fields persist across commits, so a later commit may rewrite
    // just one of them
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            range_q <= '0;
        end else if (cfg_accept) begin
            case (cfg_word_i.op)
                csr_index_pkg::CFG_BASE: begin
                    range_q.base <= cfg_word_i.data;
                end
                csr_index_pkg::CFG_FIRST: begin
                    range_q.first <= cfg_word_i.data;
                end
                csr_index_pkg::CFG_LAST: begin
                    range_q.last <= cfg_word_i.data;
                end
                default: begin
                    // COMMIT leaves the record as it is
                    range_q <= range_q;
                end
            endcase
        end
    end

    // --------------------
    // Commit
    // --------------------
    // Record enters the buffer on the same edge the COMMIT word is taken
    assign push_o  = cfg_accept & (cfg_word_i.op == csr_index_pkg::CFG_COMMIT);
    assign range_o = range_q;

endmodule : csr_index_configure

/* logic/csr_index_pkg.sv */
/*
 * Shared widths, buffer sizing, opcode and state enums, and the packed
 * records that travel between configuration, buffer, generator and memory
 */

package csr_index_pkg;

    // --------------------
    // Widths and sizing
    // --------------------
    localparam int DATA_W      = 32;
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_AW     = 2;
    // Byte distance between neighbouring CSR entries
    localparam int ENTRY_BYTES = 4;

    // --------------------
    // Enums
    // --------------------
    typedef enum logic [1:0] {
        CFG_BASE   = 2'd0,
        CFG_FIRST  = 2'd1,
        CFG_LAST   = 2'd2,
        CFG_COMMIT = 2'd3
    } cfg_op_e;

    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_LOAD = 2'd1,
        GEN_REQ  = 2'd2,
        GEN_NEXT = 2'd3
    } gen_state_e;

    // --------------------
    // Records
    // --------------------
    // One configuration word from the outside
    typedef struct packed {
        logic              valid;
        cfg_op_e           op;
        logic [DATA_W-1:0] data;
    } cfg_word_t;

    // Range of CSR indexes to walk, inclusive on both ends
    typedef struct packed {
        logic [DATA_W-1:0] base;
        logic [DATA_W-1:0] first;
        logic [DATA_W-1:0] last;
    } csr_range_t;

    // Job descriptor, number of ranges that make up one job
    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] job_count;
    } descriptor_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [DATA_W-1:0] adr;
    } wb_req_t;

    // Wishbone classic slave outputs
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // Returned word tagged with the index it was read from
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] index;
        logic [DATA_W-1:0] data;
    } idx_pkt_t;

endpackage : csr_index_pkg
